//--- Makefile
VERILATOR  ?= verilator
FILELIST   ?= src.f
TB_TOP     ?= tb_dyn_shell
RTL_TOP    ?= dyn_shell_top
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- rtl/axis_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axis_if;
    dyn_pkg::data_t      tdata;
    dyn_pkg::keep_t      tkeep;
    dyn_pkg::region_id_t tid;
    logic                tlast;
    logic                tvalid;
    logic                tready;

    // Source side drives the beat
    modport src (
        output tdata, tkeep, tid, tlast, tvalid,
        input  tready
    );

    // Sink side answers with ready
    modport snk (
        input  tdata, tkeep, tid, tlast, tvalid,
        output tready
    );
endinterface

`default_nettype wire

//--- rtl/axis_reg_slice.sv
`timescale 1ns/1ps
`default_nettype none

module axis_reg_slice (
    input  logic aclk,
    input  logic aresetn,
    axis_if.snk  s,
    axis_if.src  m
);
    import dyn_pkg::*;

    // Main stage, drives the output
    logic       main_valid;
    data_t      main_data;
    keep_t      main_keep;
    region_id_t main_id;
    logic       main_last;

    // Spare stage, catches a beat while main is stalled
    logic       spare_valid;
    data_t      spare_data;
    keep_t      spare_keep;
    region_id_t spare_id;
    logic       spare_last;

    logic s_fire;
    logic main_load;

    // Ready comes straight from a flop
    assign s.tready  = ~spare_valid;
    assign s_fire    = s.tvalid & ~spare_valid;
    assign main_load = ~main_valid | m.tready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            main_valid  <= 1'b0;
            spare_valid <= 1'b0;
        end else begin
            if (main_load) begin
                main_valid  <= spare_valid | s_fire;
                spare_valid <= 1'b0;
            end else if (s_fire) begin
                spare_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (main_load) begin
            // Spare holds the older beat, so it goes first
            if (spare_valid) begin
                main_data <= spare_data;
                main_keep <= spare_keep;
                main_id   <= spare_id;
                main_last <= spare_last;
            end else begin
                main_data <= s.tdata;
                main_keep <= s.tkeep;
                main_id   <= s.tid;
                main_last <= s.tlast;
            end
        end
        if (s_fire && !main_load) begin
            spare_data <= s.tdata;
            spare_keep <= s.tkeep;
            spare_id   <= s.tid;
            spare_last <= s.tlast;
        end
    end

    assign m.tvalid = main_valid;
    assign m.tdata  = main_data;
    assign m.tkeep  = main_keep;
    assign m.tid    = main_id;
    assign m.tlast  = main_last;

    a_hold_stalled: assert property (@(posedge aclk) disable iff (!aresetn)
        m.tvalid && !m.tready |=> m.tvalid && $stable(m.tdata) && $stable(m.tkeep)
            && $stable(m.tid) && $stable(m.tlast))
        else $error("axis_reg_slice: output beat changed while stalled");

endmodule

`default_nettype wire

//--- rtl/dyn_defines.svh
`ifndef DYN_DEFINES_SVH
`define DYN_DEFINES_SVH

// Stream data width in bits
`define DYN_DATA_BITS 64

// Dynamic regions behind the host stream
`define DYN_N_REGIONS 4

// Width of a region index, log2 of the region count
`define DYN_ID_BITS 2

// Register stages on the decouple request
`define DYN_DCPL_STAGES 3

`endif

//--- rtl/dyn_pkg.sv
`default_nettype none

`include "dyn_defines.svh"

package dyn_pkg;

    // One stream word and its byte enables
    typedef logic [`DYN_DATA_BITS-1:0]   data_t;
    typedef logic [`DYN_DATA_BITS/8-1:0] keep_t;

    // Region index as carried in tid
    typedef logic [`DYN_ID_BITS-1:0]     region_id_t;

    // One bit per region
    typedef logic [`DYN_N_REGIONS-1:0]   region_mask_t;

endpackage

`default_nettype wire

//--- rtl/dyn_shell_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dyn_defines.svh"

module dyn_shell_top (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  dyn_pkg::region_mask_t decouple,

    // Host stream in
    input  dyn_pkg::data_t        s_axis_host_tdata,
    input  dyn_pkg::keep_t        s_axis_host_tkeep,
    input  dyn_pkg::region_id_t   s_axis_host_tid,
    input  logic                  s_axis_host_tlast,
    input  logic                  s_axis_host_tvalid,
    output logic                  s_axis_host_tready,

    // Host stream out
    output dyn_pkg::data_t        m_axis_host_tdata,
    output dyn_pkg::keep_t        m_axis_host_tkeep,
    output dyn_pkg::region_id_t   m_axis_host_tid,
    output logic                  m_axis_host_tlast,
    output logic                  m_axis_host_tvalid,
    input  logic                  m_axis_host_tready,

    // Streams towards the regions
    output dyn_pkg::data_t        m_axis_region_tdata  [`DYN_N_REGIONS],
    output dyn_pkg::keep_t        m_axis_region_tkeep  [`DYN_N_REGIONS],
    output logic                  m_axis_region_tlast  [`DYN_N_REGIONS],
    output logic                  m_axis_region_tvalid [`DYN_N_REGIONS],
    input  dyn_pkg::region_mask_t m_axis_region_tready,

    // Streams from the regions
    input  dyn_pkg::data_t        s_axis_region_tdata  [`DYN_N_REGIONS],
    input  dyn_pkg::keep_t        s_axis_region_tkeep  [`DYN_N_REGIONS],
    input  logic                  s_axis_region_tlast  [`DYN_N_REGIONS],
    input  logic                  s_axis_region_tvalid [`DYN_N_REGIONS],
    output dyn_pkg::region_mask_t s_axis_region_tready
);
    import dyn_pkg::*;

    axis_if host_raw ();
    axis_if host_in ();
    axis_if dmx_out  [`DYN_N_REGIONS] ();
    axis_if reg_down [`DYN_N_REGIONS] ();
    axis_if reg_src  [`DYN_N_REGIONS] ();
    axis_if reg_up   [`DYN_N_REGIONS] ();
    axis_if arb_out ();
    axis_if host_out ();

    // ---------------------------------------------------------
    // Host ports
    // ---------------------------------------------------------
    assign host_raw.tdata     = s_axis_host_tdata;
    assign host_raw.tkeep     = s_axis_host_tkeep;
    assign host_raw.tid       = s_axis_host_tid;
    assign host_raw.tlast     = s_axis_host_tlast;
    assign host_raw.tvalid    = s_axis_host_tvalid;
    assign s_axis_host_tready = host_raw.tready;

    assign m_axis_host_tdata  = host_out.tdata;
    assign m_axis_host_tkeep  = host_out.tkeep;
    assign m_axis_host_tid    = host_out.tid;
    assign m_axis_host_tlast  = host_out.tlast;
    assign m_axis_host_tvalid = host_out.tvalid;
    assign host_out.tready    = m_axis_host_tready;

    // ---------------------------------------------------------
    // Region ports on the decoupler's outer side
    // ---------------------------------------------------------
    for (genvar i = 0; i < `DYN_N_REGIONS; i++) begin : g_region
        assign m_axis_region_tdata[i]  = reg_down[i].tdata;
        assign m_axis_region_tkeep[i]  = reg_down[i].tkeep;
        assign m_axis_region_tlast[i]  = reg_down[i].tlast;
        assign m_axis_region_tvalid[i] = reg_down[i].tvalid;
        assign reg_down[i].tready      = m_axis_region_tready[i];

        assign reg_src[i].tdata        = s_axis_region_tdata[i];
        assign reg_src[i].tkeep        = s_axis_region_tkeep[i];
        assign reg_src[i].tlast        = s_axis_region_tlast[i];
        assign reg_src[i].tvalid       = s_axis_region_tvalid[i];
        // Regions carry no tid of their own
        assign reg_src[i].tid          = region_id_t'(i);
        assign s_axis_region_tready[i] = reg_src[i].tready;
    end

    axis_reg_slice inst_host_in (
        .aclk    (aclk),
        .aresetn (aresetn),
        .s       (host_raw),
        .m       (host_in)
    );

    region_demux inst_demux (
        .aclk    (aclk),
        .aresetn (aresetn),
        .s       (host_in),
        .m       (dmx_out)
    );

    region_decoupler inst_decoupler (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .decouple (decouple),
        .s_down   (dmx_out),
        .m_down   (reg_down),
        .s_up     (reg_src),
        .m_up     (reg_up)
    );

    region_arbiter inst_arbiter (
        .aclk    (aclk),
        .aresetn (aresetn),
        .s       (reg_up),
        .m       (arb_out)
    );

    axis_reg_slice inst_host_out (
        .aclk    (aclk),
        .aresetn (aresetn),
        .s       (arb_out),
        .m       (host_out)
    );

endmodule

`default_nettype wire

//--- rtl/region_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "dyn_defines.svh"

module region_arbiter (
    input  logic aclk,
    input  logic aresetn,
    axis_if.snk  s [`DYN_N_REGIONS],
    axis_if.src  m
);
    import dyn_pkg::*;

    localparam int N = `DYN_N_REGIONS;

    // Flattened region inputs
    region_mask_t req;
    region_mask_t in_last;
    data_t        in_data [N];
    keep_t        in_keep [N];

    // Arbitration state
    region_id_t   ptr;
    region_id_t   grant;
    logic         locked;

    region_id_t   pick;
    logic         pick_ok;
    region_id_t   sel;
    logic         sel_ok;
    logic         out_free;
    logic         in_fire;

    // Output register
    logic         out_valid;
    data_t        out_data;
    keep_t        out_keep;
    region_id_t   out_id;
    logic         out_last;

    for (genvar i = 0; i < N; i++) begin : g_in
        assign req[i]      = s[i].tvalid;
        assign in_last[i]  = s[i].tlast;
        assign in_data[i]  = s[i].tdata;
        assign in_keep[i]  = s[i].tkeep;
        assign s[i].tready = in_fire & (sel == region_id_t'(i));
    end

    // ---------------------------------------------------------
    // Round-robin search from ptr with wraparound
    // ---------------------------------------------------------
    always_comb begin
        int idx;
        pick    = ptr;
        pick_ok = 1'b0;
        for (int k = 0; k < N; k++) begin
            idx = (int'(ptr) + k) % N;
            if (!pick_ok && req[idx]) begin
                pick    = region_id_t'(idx);
                pick_ok = 1'b1;
            end
        end
    end

    // Inside a packet the grant is fixed
    assign sel      = locked ? grant : pick;
    assign sel_ok   = locked ? req[grant] : pick_ok;
    assign out_free = ~out_valid | m.tready;
    assign in_fire  = out_free & sel_ok;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            out_valid <= 1'b0;
            ptr       <= '0;
            grant     <= '0;
            locked    <= 1'b0;
        end else begin
            if (in_fire) begin
                out_valid <= 1'b1;
                grant     <= sel;
                locked    <= ~in_last[sel];
                if (in_last[sel]) begin
                    ptr <= region_id_t'((int'(sel) + 1) % N);
                end
            end else if (m.tready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // tid becomes the source region
    always_ff @(posedge aclk) begin
        if (in_fire) begin
            out_data <= in_data[sel];
            out_keep <= in_keep[sel];
            out_id   <= sel;
            out_last <= in_last[sel];
        end
    end

    assign m.tvalid = out_valid;
    assign m.tdata  = out_data;
    assign m.tkeep  = out_keep;
    assign m.tid    = out_id;
    assign m.tlast  = out_last;

    a_grant_held: assert property (@(posedge aclk) disable iff (!aresetn)
        locked |=> grant == $past(grant))
        else $error("region_arbiter: grant moved inside a packet");

endmodule

`default_nettype wire

//--- rtl/region_decoupler.sv
`timescale 1ns/1ps
`default_nettype none

`include "dyn_defines.svh"

module region_decoupler (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  dyn_pkg::region_mask_t decouple,
    axis_if.snk                   s_down [`DYN_N_REGIONS],
    axis_if.src                   m_down [`DYN_N_REGIONS],
    axis_if.snk                   s_up   [`DYN_N_REGIONS],
    axis_if.src                   m_up   [`DYN_N_REGIONS]
);
    import dyn_pkg::*;

    region_mask_t dcpl_q [`DYN_DCPL_STAGES];
    region_mask_t dcpl;

    // Request pipeline that resets with every region coupled
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int k = 0; k < `DYN_DCPL_STAGES; k++) begin
                dcpl_q[k] <= '0;
            end
        end else begin
            dcpl_q[0] <= decouple;
            for (int k = 1; k < `DYN_DCPL_STAGES; k++) begin
                dcpl_q[k] <= dcpl_q[k-1];
            end
        end
    end

    assign dcpl = dcpl_q[`DYN_DCPL_STAGES-1];

    for (genvar i = 0; i < `DYN_N_REGIONS; i++) begin : g_region
        // Host to region
        assign m_down[i].tdata  = s_down[i].tdata;
        assign m_down[i].tkeep  = s_down[i].tkeep;
        assign m_down[i].tid    = s_down[i].tid;
        assign m_down[i].tlast  = s_down[i].tlast;
        assign m_down[i].tvalid = s_down[i].tvalid & ~dcpl[i];
        assign s_down[i].tready = m_down[i].tready & ~dcpl[i];

        // Region to host
        assign m_up[i].tdata    = s_up[i].tdata;
        assign m_up[i].tkeep    = s_up[i].tkeep;
        assign m_up[i].tid      = s_up[i].tid;
        assign m_up[i].tlast    = s_up[i].tlast;
        assign m_up[i].tvalid   = s_up[i].tvalid & ~dcpl[i];
        assign s_up[i].tready   = m_up[i].tready & ~dcpl[i];

        // Delayed bit follows the old request and silences the region
        a_no_xfer: assert property (@(posedge aclk) disable iff (!aresetn)
            dcpl[i] |-> $past(decouple[i], `DYN_DCPL_STAGES)
                && !(m_down[i].tvalid && m_down[i].tready)
                && !(s_up[i].tvalid && s_up[i].tready))
            else $error("region_decoupler: decouple timing or transfer wrong on region %0d", i);
    end

endmodule

`default_nettype wire

//--- rtl/region_demux.sv
`timescale 1ns/1ps
`default_nettype none

`include "dyn_defines.svh"

module region_demux (
    input  logic aclk,
    input  logic aresetn,
    axis_if.snk  s,
    axis_if.src  m [`DYN_N_REGIONS]
);
    import dyn_pkg::*;

    region_mask_t vld;
    region_mask_t rdy;
    logic         s_fire;

    // Host side packet tracking
    logic         mid_pkt;
    region_id_t   pkt_id;

    // A held beat that cannot leave blocks every region
    assign s.tready = ~(|vld) | (|(vld & rdy));
    assign s_fire   = s.tvalid & s.tready;

    for (genvar i = 0; i < `DYN_N_REGIONS; i++) begin : g_region
        logic       vld_q;
        data_t      data_q;
        keep_t      keep_q;
        region_id_t id_q;
        logic       last_q;
        logic       hit;

        assign hit = s_fire & (s.tid == region_id_t'(i));

        always_ff @(posedge aclk) begin
            if (!aresetn) begin
                vld_q <= 1'b0;
            end else if (hit) begin
                vld_q <= 1'b1;
            end else if (m[i].tready) begin
                vld_q <= 1'b0;
            end
        end

        always_ff @(posedge aclk) begin
            if (hit) begin
                data_q <= s.tdata;
                keep_q <= s.tkeep;
                id_q   <= s.tid;
                last_q <= s.tlast;
            end
        end

        assign vld[i]       = vld_q;
        assign rdy[i]       = m[i].tready;
        assign m[i].tvalid  = vld_q;
        assign m[i].tdata   = data_q;
        assign m[i].tkeep   = keep_q;
        assign m[i].tid     = id_q;
        assign m[i].tlast   = last_q;
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            mid_pkt <= 1'b0;
        end else if (s_fire) begin
            mid_pkt <= ~s.tlast;
        end
    end

    always_ff @(posedge aclk) begin
        if (s_fire) begin
            pkt_id <= s.tid;
        end
    end

    a_one_region: assert property (@(posedge aclk) disable iff (!aresetn)
        $onehot0(vld))
        else $error("region_demux: more than one region output valid");

    a_tid_in_pkt: assert property (@(posedge aclk) disable iff (!aresetn)
        s_fire && mid_pkt |-> s.tid == pkt_id)
        else $error("region_demux: tid changed inside a packet");

endmodule

`default_nettype wire

//--- sim/tb_dyn_shell.sv
`timescale 1ns/1ps
`default_nettype none

`include "dyn_defines.svh"

module tb_dyn_shell;
    import dyn_pkg::*;

    localparam int N     = `DYN_N_REGIONS;
    localparam int PAY_W = `DYN_DATA_BITS + `DYN_DATA_BITS/8 + 1;
    localparam int LIMIT = 5000;

    logic         aclk;
    logic         aresetn;
    region_mask_t decouple;
    data_t        s_axis_host_tdata;
    keep_t        s_axis_host_tkeep;
    region_id_t   s_axis_host_tid;
    logic         s_axis_host_tlast;
    logic         s_axis_host_tvalid;
    logic         s_axis_host_tready;
    data_t        m_axis_host_tdata;
    keep_t        m_axis_host_tkeep;
    region_id_t   m_axis_host_tid;
    logic         m_axis_host_tlast;
    logic         m_axis_host_tvalid;
    logic         m_axis_host_tready;
    data_t        m_axis_region_tdata  [N];
    keep_t        m_axis_region_tkeep  [N];
    logic         m_axis_region_tlast  [N];
    logic         m_axis_region_tvalid [N];
    region_mask_t m_axis_region_tready;
    data_t        s_axis_region_tdata  [N];
    keep_t        s_axis_region_tkeep  [N];
    logic         s_axis_region_tlast  [N];
    logic         s_axis_region_tvalid [N];
    region_mask_t s_axis_region_tready;

    // Beats still to be sent, host beats carry their tid on top
    logic [`DYN_ID_BITS+PAY_W-1:0] host_src [$];
    logic [PAY_W-1:0]              reg_src  [N][$];

    // Expected beats per region, fronts refreshed on the falling edge
    logic [PAY_W-1:0] down_exp_q [N][$];
    logic [PAY_W-1:0] up_exp_q   [N][$];
    logic [PAY_W-1:0] down_front [N];
    logic [PAY_W-1:0] up_front   [N];
    region_mask_t     down_avail;
    region_mask_t     up_avail;

    logic [31:0]  rng_state;
    logic         jitter;
    logic         rr_on;
    logic         rr_seen;
    logic         host_took;
    region_mask_t up_took;
    logic         host_mid;
    region_id_t   pkt_tid;
    region_mask_t dcpl_req;
    int           dcpl_age [N];
    logic         host_fire;
    logic [PAY_W-1:0] host_got;
    region_mask_t reg_vld;

    dyn_shell_top dut (.*);

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "stopping at the first error");
    endtask

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic int rand_len();
        return 1 + int'(next_rand() % 6);
    endfunction

    function automatic logic [PAY_W-1:0] rand_beat(input logic last);
        data_t d;
        keep_t k;
        d = {next_rand(), next_rand()};
        k = keep_t'(next_rand());
        return {d, k, last};
    endfunction

    task automatic add_host_packet(input region_id_t id, input int len);
        for (int b = 0; b < len; b++) begin
            host_src.push_back({id, rand_beat(b == len - 1)});
        end
    endtask

    task automatic add_region_packet(input int r, input int len);
        for (int b = 0; b < len; b++) begin
            reg_src[r].push_back(rand_beat(b == len - 1));
        end
    endtask

    // Mid high phase, away from both clock edges
    task automatic step_cycle();
        @(posedge aclk);
        #25;
    endtask

    function automatic bit traffic_idle();
        bit idle;
        idle = host_src.size() == 0 && !s_axis_host_tvalid && !m_axis_host_tvalid;
        for (int r = 0; r < N; r++) begin
            idle = idle && reg_src[r].size() == 0 && !s_axis_region_tvalid[r];
            idle = idle && down_exp_q[r].size() == 0 && up_exp_q[r].size() == 0;
        end
        return idle;
    endfunction

    task automatic drain_traffic(input string what);
        int n;
        n = 0;
        while (!traffic_idle() && n < LIMIT) begin
            step_cycle();
            n++;
        end
        if (!traffic_idle()) begin
            fail_run($sformatf("Timeout while draining %s traffic", what));
        end
    endtask

    // ----------------------------------------------------------
    // Drivers on the falling edge
    // ----------------------------------------------------------
    always @(negedge aclk) begin
        decouple           = dcpl_req;
        m_axis_host_tready = jitter ? (next_rand() % 4 != 0) : 1'b1;
        // Hold a beat until it is taken
        if (!s_axis_host_tvalid || host_took) begin
            if (host_src.size() != 0 && (!jitter || next_rand() % 4 != 0)) begin
                {s_axis_host_tid, s_axis_host_tdata, s_axis_host_tkeep, s_axis_host_tlast} =
                    host_src.pop_front();
                s_axis_host_tvalid = 1'b1;
            end else begin
                s_axis_host_tvalid = 1'b0;
            end
        end
        for (int r = 0; r < N; r++) begin
            m_axis_region_tready[r] = jitter ? (next_rand() % 2 == 0) : 1'b1;
            if (!s_axis_region_tvalid[r] || up_took[r]) begin
                if (reg_src[r].size() != 0 && (!jitter || next_rand() % 4 != 0)) begin
                    {s_axis_region_tdata[r], s_axis_region_tkeep[r], s_axis_region_tlast[r]} =
                        reg_src[r].pop_front();
                    s_axis_region_tvalid[r] = 1'b1;
                end else begin
                    s_axis_region_tvalid[r] = 1'b0;
                end
            end
            down_avail[r] = down_exp_q[r].size() != 0;
            up_avail[r]   = up_exp_q[r].size() != 0;
            down_front[r] = down_avail[r] ? down_exp_q[r][0] : '0;
            up_front[r]   = up_avail[r] ? up_exp_q[r][0] : '0;
        end
    end

    // Transfer tracking on the rising edge
    always @(posedge aclk) begin
        if (!aresetn) begin
            host_took <= 1'b0;
            up_took   <= '0;
            host_mid  <= 1'b0;
            pkt_tid   <= '0;
            rr_seen   <= 1'b0;
            for (int r = 0; r < N; r++) begin
                dcpl_age[r] <= 0;
            end
        end else begin
            host_took <= s_axis_host_tvalid && s_axis_host_tready;
            for (int r = 0; r < N; r++) begin
                if (m_axis_region_tvalid[r] && m_axis_region_tready[r]
                        && down_exp_q[r].size() != 0) begin
                    void'(down_exp_q[r].pop_front());
                end
                up_took[r] <= s_axis_region_tvalid[r] && s_axis_region_tready[r];
                if (s_axis_region_tvalid[r] && s_axis_region_tready[r]) begin
                    up_exp_q[r].push_back({s_axis_region_tdata[r], s_axis_region_tkeep[r],
                        s_axis_region_tlast[r]});
                end
                dcpl_age[r] <= decouple[r] ? ((dcpl_age[r] < 100) ? dcpl_age[r] + 1 : 100) : 0;
            end
            if (s_axis_host_tvalid && s_axis_host_tready) begin
                down_exp_q[s_axis_host_tid].push_back({s_axis_host_tdata, s_axis_host_tkeep,
                    s_axis_host_tlast});
            end
            if (host_fire) begin
                if (up_exp_q[m_axis_host_tid].size() != 0) begin
                    void'(up_exp_q[m_axis_host_tid].pop_front());
                end
                host_mid <= !m_axis_host_tlast;
                if (!host_mid) begin
                    pkt_tid <= m_axis_host_tid;
                    rr_seen <= rr_on;
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    assign host_fire = m_axis_host_tvalid && m_axis_host_tready;
    assign host_got  = {m_axis_host_tdata, m_axis_host_tkeep, m_axis_host_tlast};

    a_reset_quiet: assert property (@(posedge aclk)
        $rose(aresetn) |-> !m_axis_host_tvalid && reg_vld == '0)
        else fail_run("A valid output was high right after reset");

    for (genvar r = 0; r < N; r++) begin : g_chk
        logic [PAY_W-1:0] got;

        assign got        = {m_axis_region_tdata[r], m_axis_region_tkeep[r],
                             m_axis_region_tlast[r]};
        assign reg_vld[r] = m_axis_region_tvalid[r];

        a_down_known: assert property (@(posedge aclk) disable iff (!aresetn)
            m_axis_region_tvalid[r] && m_axis_region_tready[r] |-> down_avail[r])
            else fail_run($sformatf("Region %0d received a beat that was never sent", r));

        a_down_value: assert property (@(posedge aclk) disable iff (!aresetn)
            m_axis_region_tvalid[r] && m_axis_region_tready[r] && down_avail[r]
                |-> got == down_front[r])
            else begin
                $display("Mismatch host_to_region r%0d expected %h actual %h",
                    r, down_front[r], $sampled(got));
                fail_run("Region output beat differs from the host beat");
            end

        // Decoupled long enough, so the region must be silent
        a_decoupled: assert property (@(posedge aclk) disable iff (!aresetn)
            dcpl_age[r] >= `DYN_DCPL_STAGES
                |-> !m_axis_region_tvalid[r] && !s_axis_region_tready[r])
            else fail_run($sformatf("Decoupled region %0d showed valid or ready", r));
    end

    a_up_known: assert property (@(posedge aclk) disable iff (!aresetn)
        host_fire |-> up_avail[m_axis_host_tid])
        else fail_run("Host output carried a beat no region sent");

    a_up_value: assert property (@(posedge aclk) disable iff (!aresetn)
        host_fire && up_avail[m_axis_host_tid] |-> host_got == up_front[m_axis_host_tid])
        else begin
            $display("Mismatch region_to_host tid%0d expected %h actual %h",
                $sampled(m_axis_host_tid), up_front[$sampled(m_axis_host_tid)],
                $sampled(host_got));
            fail_run("Host output beat differs from the region beat");
        end

    a_pkt_whole: assert property (@(posedge aclk) disable iff (!aresetn)
        host_fire && host_mid |-> m_axis_host_tid == pkt_tid)
        else fail_run("Host output packet was interleaved with another region");

    a_round_robin: assert property (@(posedge aclk) disable iff (!aresetn)
        rr_on && rr_seen && host_fire && !host_mid
            |-> m_axis_host_tid == region_id_t'(pkt_tid + 1'b1))
        else begin
            $display("Mismatch round_robin expected %0d actual %0d",
                region_id_t'(pkt_tid + 1'b1), $sampled(m_axis_host_tid));
            fail_run("Host packets left the cyclic region order");
        end

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        rng_state            = 32'hcaf0;
        aresetn              = 1'b0;
        decouple             = '0;
        s_axis_host_tdata    = '0;
        s_axis_host_tkeep    = '0;
        s_axis_host_tid      = '0;
        s_axis_host_tlast    = 1'b0;
        s_axis_host_tvalid   = 1'b0;
        m_axis_host_tready   = 1'b0;
        m_axis_region_tready = '0;
        for (int r = 0; r < N; r++) begin
            s_axis_region_tdata[r]  = '0;
            s_axis_region_tkeep[r]  = '0;
            s_axis_region_tlast[r]  = 1'b0;
            s_axis_region_tvalid[r] = 1'b0;
        end
        jitter     = 1'b0;
        rr_on      = 1'b0;
        dcpl_req   = '0;
        down_avail = '0;
        up_avail   = '0;
        repeat (3) @(negedge aclk);
        aresetn = 1'b1;
        step_cycle();

        // Both directions with random readiness
        jitter = 1'b1;
        for (int p = 0; p < 24; p++) begin
            add_host_packet(region_id_t'(next_rand()), rand_len());
        end
        for (int r = 0; r < N; r++) begin
            for (int p = 0; p < 6; p++) begin
                add_region_packet(r, rand_len());
            end
        end
        drain_traffic("random");

        // All regions loaded, host always ready
        jitter = 1'b0;
        rr_on  = 1'b1;
        for (int p = 0; p < 5; p++) begin
            for (int r = 0; r < N; r++) begin
                add_region_packet(r, rand_len());
            end
        end
        drain_traffic("round robin");
        rr_on = 1'b0;

        // Region 2 decoupled in the middle of traffic
        jitter = 1'b1;
        for (int p = 0; p < 16; p++) begin
            add_host_packet(region_id_t'(next_rand()), rand_len());
        end
        for (int r = 0; r < N; r++) begin
            for (int p = 0; p < 4; p++) begin
                add_region_packet(r, rand_len());
            end
        end
        repeat (6) step_cycle();
        dcpl_req = 4'b0100;
        repeat (30) step_cycle();
        dcpl_req = '0;
        drain_traffic("decouple release");

        if (traffic_idle()) begin
            $display("Testbench passed");
            $finish;
        end else begin
            fail_run("Traffic was still pending at the end of the run");
        end
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+rtl
rtl/dyn_pkg.sv
rtl/axis_if.sv
rtl/axis_reg_slice.sv
rtl/region_demux.sv
rtl/region_decoupler.sv
rtl/region_arbiter.sv
rtl/dyn_shell_top.sv
sim/tb_dyn_shell.sv
